//--- src.f
logic/l1d_cfg_pkg.sv
logic/l1d_msg_pkg.sv
logic/l1d_array_if.sv
logic/l1d_mshr_if.sv
logic/l1d_tag_data_array.sv
logic/l1d_mshr_file.sv
logic/l1d_controller.sv
logic/l1_data_cache.sv
verification/l1d_tb.sv

//--- Makefile
SRCS := $(shell cat src.f)

.PHONY: all run clean

all: obj_dir/Vl1d_tb

obj_dir/Vl1d_tb: src.f $(SRCS)
	verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module l1d_tb -f src.f

run: obj_dir/Vl1d_tb
	./obj_dir/Vl1d_tb | tee /dev/stderr | grep -q "^Finished with no errors$$"

clean:
	rm -rf obj_dir

//--- verification/l1d_tb.sv
// the lower level takes every request at once and returns fills in order after at least 12 cycles
`timescale 1ns/1ps

module l1d_tb;

  typedef struct packed {
    logic [2:0] test;
    logic sync;
    l1d_cfg_pkg::paddr_t addr;
    logic we;
    l1d_cfg_pkg::word_t data;
    l1d_msg_pkg::req_tag_t tag;
  } row_t;

  // expected line reads and writebacks per test, and the tag that must answer first if any
  typedef struct packed {
    logic [1:0] reads;
    logic wbs;
    l1d_msg_pkg::req_tag_t first_tag;
    logic stall;
  } test_t;

  localparam int NROWS = 15;
  localparam int NTESTS = 6;
  localparam int LIMIT = 400;

  logic clk_in = 1'b0;
  logic rst_N_in = 1'b0;
  logic lsu_req_valid_in = 1'b0;
  l1d_cfg_pkg::paddr_t lsu_req_addr_in = '0;
  l1d_cfg_pkg::word_t lsu_req_wdata_in = '0;
  logic lsu_req_we_in = 1'b0;
  l1d_msg_pkg::req_tag_t lsu_req_tag_in = '0;
  logic lsu_resp_ready_in = 1'b1;
  logic lc_req_ready_in = 1'b1;
  logic lc_fill_valid_in = 1'b0;
  l1d_cfg_pkg::line_addr_t lc_fill_addr_in = '0;
  l1d_cfg_pkg::line_t lc_fill_line_in = '0;
  logic lsu_req_ready_out, lsu_resp_valid_out, lsu_resp_we_out;
  l1d_msg_pkg::req_tag_t lsu_resp_tag_out;
  l1d_cfg_pkg::word_t lsu_resp_rdata_out;
  logic lc_req_valid_out, lc_req_we_out, lc_fill_ready_out;
  l1d_cfg_pkg::line_addr_t lc_req_addr_out;
  l1d_cfg_pkg::line_t lc_req_line_out;

  row_t rows [NROWS];
  test_t tests [NTESTS];
  string names [NTESTS];
  l1d_cfg_pkg::word_t ref_mem [l1d_cfg_pkg::paddr_t];
  l1d_cfg_pkg::line_t lc_mem [l1d_cfg_pkg::line_addr_t];
  l1d_msg_pkg::lsu_resp_t exp_q [l1d_msg_pkg::req_tag_t];
  l1d_msg_pkg::req_tag_t order_q [$];
  l1d_cfg_pkg::line_addr_t fill_q [$];
  l1d_msg_pkg::lsu_resp_t got, held;
  logic stalled = 1'b0;
  logic timed_out = 1'b0;
  logic [63:0] rng = 64'd13;
  int fill_delay = -1;
  int errors = 0;
  int lc_reads = 0;
  int lc_wbs = 0;
  int lc_fills = 0;

  l1_data_cache i_dut (.*);

  always #50 clk_in = ~clk_in;

  assign got = '{tag: lsu_resp_tag_out, rdata: lsu_resp_rdata_out, we: lsu_resp_we_out};

  function automatic logic [63:0] xorshift(logic [63:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  // every word of the lower level starts as a scramble of its full byte address
  function automatic l1d_cfg_pkg::word_t init_word(l1d_cfg_pkg::paddr_t a);
    return xorshift(xorshift(64'd13 ^ 64'(a)));
  endfunction

  function automatic l1d_cfg_pkg::word_t ref_word(l1d_cfg_pkg::paddr_t a);
    return ref_mem.exists(a) ? ref_mem[a] : init_word(a);
  endfunction

  function automatic l1d_cfg_pkg::line_t build_line(l1d_cfg_pkg::line_addr_t la, logic use_ref);
    l1d_cfg_pkg::line_t l;
    l1d_cfg_pkg::paddr_t a;
    for (int w = 0; w < l1d_cfg_pkg::LINE_WORDS; w++) begin
      a = l1d_cfg_pkg::paddr_t'({la, l1d_cfg_pkg::word_sel_t'(w)}) << l1d_cfg_pkg::BYTE_OFF_BITS;
      l[w] = use_ref ? ref_word(a) : init_word(a);
    end
    return l;
  endfunction

  task automatic check_resp(input l1d_msg_pkg::lsu_resp_t seen, input l1d_msg_pkg::lsu_resp_t want);
    if (seen !== want) begin
      $display("ERR %0t: tag %0d gave rdata %h we %b, expected rdata %h we %b", $time,
               seen.tag, seen.rdata, seen.we, want.rdata, want.we);
      errors++;
    end
  endtask

  task automatic check_line(input l1d_cfg_pkg::line_t seen, input l1d_cfg_pkg::line_t want,
                            input l1d_cfg_pkg::line_addr_t la);
    if (seen !== want) begin
      $display("ERR %0t: writeback of line %h was %h, expected %h", $time, la, seen, want);
      errors++;
    end
  endtask

  task automatic report_timeout(input string what);
    $display("timeout at %0t: %s", $time, what);
    timed_out = 1'b1;
  endtask

  // the expected response is fixed by the reference memory at the moment of acceptance
  task automatic issue_request(input row_t row);
    int waited;
    logic taken;
    waited = 0;
    taken = 1'b0;
    @(posedge clk_in);
    lsu_req_valid_in <= 1'b1;
    lsu_req_addr_in <= row.addr;
    lsu_req_wdata_in <= row.data;
    lsu_req_we_in <= row.we;
    lsu_req_tag_in <= row.tag;
    while (!taken && waited < LIMIT) begin
      @(posedge clk_in);
      waited++;
      taken = lsu_req_ready_out;
    end
    lsu_req_valid_in <= 1'b0;
    if (!taken) begin
      report_timeout("the cache never accepted a request");
    end else begin
      exp_q[row.tag] = '{tag: row.tag, rdata: ref_word(row.addr), we: row.we};
      if (row.we) ref_mem[row.addr] = row.data;
    end
  endtask

  task automatic wait_for_responses();
    int waited;
    waited = 0;
    while (exp_q.num() != 0 && waited < LIMIT) begin
      @(negedge clk_in);
      waited++;
    end
    if (exp_q.num() != 0) begin
      report_timeout("some responses never arrived");
    end else begin
      @(posedge clk_in);
    end
  endtask

  always @(posedge clk_in) begin
    if (rst_N_in) begin
      // a response held back by the LSU has to stay put
      if (stalled && (!lsu_resp_valid_out || got !== held)) begin
        $display("ERR %0t: response changed while the LSU was not ready", $time);
        errors++;
      end
      stalled = lsu_resp_valid_out && !lsu_resp_ready_in;
      held = got;
      if (lsu_resp_valid_out && lsu_resp_ready_in) begin
        if (exp_q.exists(got.tag)) begin
          check_resp(got, exp_q[got.tag]);
          exp_q.delete(got.tag);
          order_q.push_back(got.tag);
        end else begin
          $display("response with tag %0d was not expected at %0t", got.tag, $time);
          errors++;
        end
      end
    end
  end

  // lower level model, which takes writebacks and queues line reads for a delayed fill
  always @(posedge clk_in) begin
    if (rst_N_in) begin
      if (lc_req_valid_out && lc_req_ready_in) begin
        if (lc_req_we_out) begin
          check_line(lc_req_line_out, build_line(lc_req_addr_out, 1'b1), lc_req_addr_out);
          lc_mem[lc_req_addr_out] = lc_req_line_out;
          lc_wbs++;
        end else begin
          fill_q.push_back(lc_req_addr_out);
          lc_reads++;
        end
      end
      if (lc_fill_valid_in) begin
        if (lc_fill_ready_out) begin
          lc_fill_valid_in <= 1'b0;
          lc_fills++;
        end
      end else if (fill_q.size() != 0) begin
        if (fill_delay < 0) begin
          rng = xorshift(rng);
          fill_delay = 12 + int'(rng[3:0]);
        end else if (fill_delay == 0) begin
          lc_fill_valid_in <= 1'b1;
          lc_fill_addr_in <= fill_q[0];
          lc_fill_line_in <= lc_mem.exists(fill_q[0]) ? lc_mem[fill_q[0]]
                                                      : build_line(fill_q[0], 1'b0);
          void'(fill_q.pop_front());
          fill_delay = -1;
        end else begin
          fill_delay--;
        end
      end
    end
  end

  initial begin
    int r, reads0, wbs0, fills0, errs0, first_at, waited, ran;
    logic synced;
    rows = '{
      '{3'd0, 1'b0, 22'h000100, 1'b0, 64'h0, 6'd1},
      '{3'd0, 1'b1, 22'h000108, 1'b0, 64'h0, 6'd2},
      '{3'd1, 1'b0, 22'h000110, 1'b1, 64'hA5A5_0000_1111_0001, 6'd3},
      '{3'd1, 1'b0, 22'h000110, 1'b0, 64'h0, 6'd4},
      '{3'd2, 1'b0, 22'h000200, 1'b0, 64'h0, 6'd5},
      '{3'd2, 1'b0, 22'h000208, 1'b1, 64'hA5A5_0000_2222_0002, 6'd6},
      '{3'd2, 1'b0, 22'h000208, 1'b0, 64'h0, 6'd7},
      '{3'd2, 1'b0, 22'h000200, 1'b1, 64'hA5A5_0000_3333_0003, 6'd8},
      '{3'd3, 1'b0, 22'h000340, 1'b0, 64'h0, 6'd9},
      '{3'd3, 1'b0, 22'h000118, 1'b0, 64'h0, 6'd10},
      '{3'd4, 1'b0, 22'h000120, 1'b1, 64'hA5A5_0000_4444_0004, 6'd11},
      '{3'd4, 1'b1, 22'h000520, 1'b0, 64'h0, 6'd12},
      '{3'd5, 1'b0, 22'h000620, 1'b0, 64'h0, 6'd13},
      '{3'd5, 1'b0, 22'h000628, 1'b1, 64'hA5A5_0000_5555_0005, 6'd14},
      '{3'd5, 1'b0, 22'h000628, 1'b0, 64'h0, 6'd15}
    };
    tests = '{'{2'd1, 1'b0, 6'd0, 1'b0}, '{2'd0, 1'b0, 6'd0, 1'b0}, '{2'd1, 1'b0, 6'd0, 1'b0},
              '{2'd1, 1'b0, 6'd10, 1'b0}, '{2'd2, 1'b1, 6'd0, 1'b0}, '{2'd1, 1'b0, 6'd0, 1'b1}};
    names = '{"miss then hit", "write hit then read", "secondary misses", "hit under miss",
              "dirty eviction", "back-pressure"};
    repeat (2) @(posedge clk_in);
    rst_N_in <= 1'b1;
    r = 0;
    ran = 0;
    for (int t = 0; t < NTESTS && !timed_out; t++) begin
      reads0 = lc_reads;
      wbs0 = lc_wbs;
      fills0 = lc_fills;
      errs0 = errors;
      first_at = order_q.size();
      synced = 1'b0;
      lsu_resp_ready_in <= !tests[t].stall;
      while (!timed_out && r < NROWS && rows[r].test == 3'(t)) begin
        if (rows[r].sync) begin
          synced = 1'b1;
          wait_for_responses();
        end
        if (!timed_out) issue_request(rows[r]);
        r++;
      end
      // without a sync point all requests of a test go in while its misses are still pending
      if (!timed_out && !synced && lc_fills != fills0) begin
        $display("a fill came back before test %0d had issued all its requests", t + 1);
        errors++;
      end
      if (!timed_out && tests[t].stall) begin
        waited = 0;
        while (!lsu_resp_valid_out && waited < LIMIT) begin
          @(posedge clk_in);
          waited++;
        end
        if (!lsu_resp_valid_out) begin
          report_timeout("no response showed up during back-pressure");
        end else begin
          repeat (10) @(posedge clk_in);
          lsu_resp_ready_in <= 1'b1;
        end
      end
      if (!timed_out) wait_for_responses();
      if (!timed_out) begin
        if (lc_reads - reads0 != int'(tests[t].reads) ||
            lc_wbs - wbs0 != int'(tests[t].wbs)) begin
          $display("ERR %0t: %0d line reads and %0d writebacks, expected %0d and %0d", $time,
                   lc_reads - reads0, lc_wbs - wbs0, tests[t].reads, tests[t].wbs);
          errors++;
        end
        if (tests[t].first_tag != '0 && order_q[first_at] != tests[t].first_tag) begin
          $display("ERR %0t: tag %0d answered first, expected tag %0d", $time,
                   order_q[first_at], tests[t].first_tag);
          errors++;
        end
        $display("test %0d (%s) done with %0d errors", t + 1, names[t], errors - errs0);
        ran++;
      end
    end
    $display("%0d tests run, %0d errors in total", ran, errors);
    if (errors == 0 && !timed_out) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- logic/l1_data_cache.sv
// physical addresses only and responses can return out of order so the LSU must pair them by tag
`timescale 1ns/1ps

module l1_data_cache #(
  parameter int SETS = 16,
  parameter int MSHR_COUNT = 4,
  parameter int MSHR_DEPTH = 4
) (
  input logic clk_in,
  input logic rst_N_in,
  input logic lsu_req_valid_in,
  input l1d_cfg_pkg::paddr_t lsu_req_addr_in,
  input l1d_cfg_pkg::word_t lsu_req_wdata_in,
  input logic lsu_req_we_in,
  input l1d_msg_pkg::req_tag_t lsu_req_tag_in,
  output logic lsu_req_ready_out,
  output logic lsu_resp_valid_out,
  output l1d_msg_pkg::req_tag_t lsu_resp_tag_out,
  output l1d_cfg_pkg::word_t lsu_resp_rdata_out,
  output logic lsu_resp_we_out,
  input logic lsu_resp_ready_in,
  output logic lc_req_valid_out,
  output l1d_cfg_pkg::line_addr_t lc_req_addr_out,
  output logic lc_req_we_out,
  output l1d_cfg_pkg::line_t lc_req_line_out,
  input logic lc_req_ready_in,
  input logic lc_fill_valid_in,
  input l1d_cfg_pkg::line_addr_t lc_fill_addr_in,
  input l1d_cfg_pkg::line_t lc_fill_line_in,
  output logic lc_fill_ready_out
);

  l1d_array_if arr_if ();
  l1d_mshr_if #(.MSHR_COUNT(MSHR_COUNT)) mshr_if ();

  // every external channel passes straight through to the FSM by name
  l1d_controller i_ctrl (.*, .arr(arr_if.ctrl), .mshr(mshr_if.ctrl));

  l1d_tag_data_array #(.SETS(SETS)) i_array (.clk_in, .rst_N_in, .port(arr_if.array));

  l1d_mshr_file #(
    .MSHR_COUNT(MSHR_COUNT),
    .MSHR_DEPTH(MSHR_DEPTH)
  ) i_mshr (.clk_in, .rst_N_in, .port(mshr_if.mshr));

endmodule

//--- logic/l1d_controller.sv
// only one request or fill is in flight inside the FSM and a waiting fill wins over a new request
`timescale 1ns/1ps

module l1d_controller (
  input logic clk_in,
  input logic rst_N_in,
  input logic lsu_req_valid_in,
  input l1d_cfg_pkg::paddr_t lsu_req_addr_in,
  input l1d_cfg_pkg::word_t lsu_req_wdata_in,
  input logic lsu_req_we_in,
  input l1d_msg_pkg::req_tag_t lsu_req_tag_in,
  output logic lsu_req_ready_out,
  output logic lsu_resp_valid_out,
  output l1d_msg_pkg::req_tag_t lsu_resp_tag_out,
  output l1d_cfg_pkg::word_t lsu_resp_rdata_out,
  output logic lsu_resp_we_out,
  input logic lsu_resp_ready_in,
  output logic lc_req_valid_out,
  output l1d_cfg_pkg::line_addr_t lc_req_addr_out,
  output logic lc_req_we_out,
  output l1d_cfg_pkg::line_t lc_req_line_out,
  input logic lc_req_ready_in,
  input logic lc_fill_valid_in,
  input l1d_cfg_pkg::line_addr_t lc_fill_addr_in,
  input l1d_cfg_pkg::line_t lc_fill_line_in,
  output logic lc_fill_ready_out,
  l1d_array_if.ctrl arr,
  l1d_mshr_if.ctrl mshr
);

  typedef enum logic [3:0] {
    ST_IDLE, ST_LOOKUP, ST_RESPOND, ST_REQ_LINE, ST_FILL_WB,
    ST_FILL_WRITE, ST_REPLAY_LOOKUP, ST_REPLAY_RESP, ST_RELEASE
  } state_t;

  state_t state_q, state_d;
  logic up_q;
  logic accept, fill_take;
  l1d_msg_pkg::lsu_req_t req_in, cur_q;
  l1d_msg_pkg::lsu_resp_t resp;
  l1d_cfg_pkg::line_addr_t fill_addr_q;
  l1d_cfg_pkg::line_t fill_line_q;

  assign req_in = '{addr: lsu_req_addr_in, wdata: lsu_req_wdata_in,
                    we: lsu_req_we_in, tag: lsu_req_tag_in};

  // take a request only if its miss could be parked in an MSHR
  assign lc_fill_ready_out = up_q && (state_q == ST_IDLE);
  assign lsu_req_ready_out = lc_fill_ready_out && !lc_fill_valid_in &&
                             (mshr.match ? !mshr.match_full : mshr.free_any);
  assign accept = lsu_req_valid_in && lsu_req_ready_out;
  assign fill_take = lc_fill_valid_in && lc_fill_ready_out;

  assign mshr.probe_addr = (state_q == ST_IDLE) ? l1d_cfg_pkg::line_of(lsu_req_addr_in)
                                                : l1d_cfg_pkg::line_of(cur_q.addr);
  assign mshr.entry = cur_q;
  assign mshr.alloc = (state_q == ST_LOOKUP) && !arr.hit && !mshr.match;
  assign mshr.append = (state_q == ST_LOOKUP) && !arr.hit && mshr.match;
  assign mshr.refill_addr = fill_addr_q;
  assign mshr.pop = (state_q == ST_REPLAY_LOOKUP);
  assign mshr.retire = (state_q == ST_RELEASE);

  // a fill is looked up first only to learn what it evicts
  assign arr.lookup = accept || fill_take || (state_q == ST_REPLAY_LOOKUP);
  assign arr.write = ((state_q == ST_LOOKUP) && arr.hit && cur_q.we) ||
                     ((state_q == ST_REPLAY_LOOKUP) && mshr.head.we);
  assign arr.wdata = (state_q == ST_REPLAY_LOOKUP) ? mshr.head.wdata : cur_q.wdata;
  assign arr.fill = (state_q == ST_FILL_WRITE);
  assign arr.fill_line = fill_line_q;

  always_comb begin
    arr.line_addr = l1d_cfg_pkg::line_of(cur_q.addr);
    arr.word_off = l1d_cfg_pkg::word_of(cur_q.addr);
    case (state_q)
      ST_IDLE: begin
        arr.line_addr = lc_fill_valid_in ? lc_fill_addr_in
                                         : l1d_cfg_pkg::line_of(lsu_req_addr_in);
        arr.word_off = l1d_cfg_pkg::word_of(lsu_req_addr_in);
      end
      ST_FILL_WRITE: arr.line_addr = fill_addr_q;
      ST_REPLAY_LOOKUP: begin
        arr.line_addr = l1d_cfg_pkg::line_of(mshr.head.addr);
        arr.word_off = l1d_cfg_pkg::word_of(mshr.head.addr);
      end
      default: ;
    endcase
  end

  assign resp = '{tag: cur_q.tag, rdata: arr.rdata, we: cur_q.we};
  assign lsu_resp_valid_out = (state_q == ST_RESPOND) || (state_q == ST_REPLAY_RESP);
  assign lsu_resp_tag_out = resp.tag;
  assign lsu_resp_rdata_out = resp.rdata;
  assign lsu_resp_we_out = resp.we;

  // the lower channel carries either a line read or a dirty victim
  assign lc_req_valid_out = (state_q == ST_REQ_LINE) || ((state_q == ST_FILL_WB) && arr.victim_dirty);
  assign lc_req_we_out = (state_q == ST_FILL_WB);
  assign lc_req_addr_out = lc_req_we_out ? arr.victim_addr : l1d_cfg_pkg::line_of(cur_q.addr);
  assign lc_req_line_out = arr.victim_line;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (fill_take) begin
          state_d = ST_FILL_WB;
        end else if (accept) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: state_d = arr.hit ? ST_RESPOND : (mshr.match ? ST_IDLE : ST_REQ_LINE);
      ST_RESPOND: if (lsu_resp_ready_in) state_d = ST_IDLE;
      ST_REQ_LINE: if (lc_req_ready_in) state_d = ST_IDLE;
      ST_FILL_WB: if (!arr.victim_dirty || lc_req_ready_in) state_d = ST_FILL_WRITE;
      ST_FILL_WRITE: state_d = ST_REPLAY_LOOKUP;
      ST_REPLAY_LOOKUP: state_d = ST_REPLAY_RESP;
      ST_REPLAY_RESP: begin
        if (lsu_resp_ready_in) begin
          state_d = mshr.head_valid ? ST_REPLAY_LOOKUP : ST_RELEASE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q <= ST_IDLE;
      up_q <= 1'b0;
    end else begin
      state_q <= state_d;
      up_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_in) begin
    if (accept) begin
      cur_q <= req_in;
    end else if (state_q == ST_REPLAY_LOOKUP) begin
      cur_q <= mshr.head;
    end
    if (fill_take) begin
      fill_addr_q <= lc_fill_addr_in;
      fill_line_q <= lc_fill_line_in;
    end
  end

endmodule

//--- logic/l1d_mshr_file.sv
// MSHR_DEPTH must be a power of two of at least two so that the queue pointers wrap on their own
`timescale 1ns/1ps

module l1d_mshr_file #(
  parameter int MSHR_COUNT = 4,
  parameter int MSHR_DEPTH = 4
) (
  input logic clk_in,
  input logic rst_N_in,
  l1d_mshr_if.mshr port
);

  localparam int IDX_BITS = $clog2(MSHR_COUNT);
  localparam int PTR_BITS = $clog2(MSHR_DEPTH);

  logic [MSHR_COUNT-1:0] valid_q;
  l1d_cfg_pkg::line_addr_t line_q [MSHR_COUNT];
  logic [PTR_BITS-1:0] head_q [MSHR_COUNT];
  logic [PTR_BITS-1:0] tail_q [MSHR_COUNT];
  logic [PTR_BITS:0] count_q [MSHR_COUNT];
  l1d_msg_pkg::lsu_req_t queue_q [MSHR_COUNT][MSHR_DEPTH];

  logic refill_hit;
  logic [IDX_BITS-1:0] push_idx;

  // scanning downward leaves the lowest free entry selected
  always_comb begin
    port.match = 1'b0;
    port.match_idx = '0;
    port.free_any = 1'b0;
    port.free_idx = '0;
    refill_hit = 1'b0;
    port.refill_idx = '0;
    for (int i = MSHR_COUNT - 1; i >= 0; i--) begin
      if (valid_q[i] && (line_q[i] == port.probe_addr)) begin
        port.match = 1'b1;
        port.match_idx = IDX_BITS'(i);
      end
      if (!valid_q[i]) begin
        port.free_any = 1'b1;
        port.free_idx = IDX_BITS'(i);
      end
      if (valid_q[i] && (line_q[i] == port.refill_addr)) begin
        refill_hit = 1'b1;
        port.refill_idx = IDX_BITS'(i);
      end
    end
    port.match_full = count_q[port.match_idx] == (PTR_BITS + 1)'(MSHR_DEPTH);
    port.head = queue_q[port.refill_idx][head_q[port.refill_idx]];
    port.head_valid = refill_hit && (count_q[port.refill_idx] != '0);
  end

  // a primary miss is pushed into a fresh entry just like a secondary one
  assign push_idx = port.alloc ? port.free_idx : port.match_idx;

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_q <= '0;
      for (int i = 0; i < MSHR_COUNT; i++) begin
        head_q[i] <= '0;
        tail_q[i] <= '0;
        count_q[i] <= '0;
      end
    end else begin
      if (port.alloc) begin
        valid_q[port.free_idx] <= 1'b1;
      end
      if (port.alloc || port.append) begin
        tail_q[push_idx] <= tail_q[push_idx] + 1'b1;
        count_q[push_idx] <= count_q[push_idx] + 1'b1;
      end
      if (port.pop) begin
        head_q[port.refill_idx] <= head_q[port.refill_idx] + 1'b1;
        count_q[port.refill_idx] <= count_q[port.refill_idx] - 1'b1;
      end
      if (port.retire) begin
        valid_q[port.refill_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (port.alloc) begin
      line_q[port.free_idx] <= port.probe_addr;
    end
    if (port.alloc || port.append) begin
      queue_q[push_idx][tail_q[push_idx]] <= port.entry;
    end
  end

endmodule

//--- logic/l1d_tag_data_array.sv
// SETS must be a power of two and a store only lands on a line that is already present
`timescale 1ns/1ps

module l1d_tag_data_array #(
  parameter int SETS = 16
) (
  input logic clk_in,
  input logic rst_N_in,
  l1d_array_if.array port
);

  localparam int IDX_BITS = $clog2(SETS);
  localparam int TAG_BITS = l1d_cfg_pkg::LINE_ADDR_BITS - IDX_BITS;

  logic [SETS-1:0] valid_q;
  logic [SETS-1:0] dirty_q;
  logic [TAG_BITS-1:0] tag_q [SETS];
  l1d_cfg_pkg::line_t data_q [SETS];

  logic [IDX_BITS-1:0] idx;
  logic [TAG_BITS-1:0] tag;
  logic tag_hit;

  // low line address bits pick the set and the rest is the stored tag
  assign idx = port.line_addr[IDX_BITS-1:0];
  assign tag = port.line_addr[l1d_cfg_pkg::LINE_ADDR_BITS-1:IDX_BITS];
  assign tag_hit = valid_q[idx] && (tag_q[idx] == tag);

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      valid_q <= '0;
      dirty_q <= '0;
      port.hit <= 1'b0;
      port.victim_dirty <= 1'b0;
    end else begin
      if (port.lookup) begin
        port.hit <= tag_hit;
        port.victim_dirty <= valid_q[idx] && dirty_q[idx];
      end
      if (port.write && tag_hit) begin
        dirty_q[idx] <= 1'b1;
      end
      // a refilled line always starts clean
      if (port.fill) begin
        valid_q[idx] <= 1'b1;
        dirty_q[idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_in) begin
    // every lookup also captures the resident line as the eviction candidate
    if (port.lookup) begin
      port.rdata <= data_q[idx][port.word_off];
      port.victim_addr <= {tag_q[idx], idx};
      port.victim_line <= data_q[idx];
    end
    if (port.write && tag_hit) begin
      data_q[idx][port.word_off] <= port.wdata;
    end
    if (port.fill) begin
      data_q[idx] <= port.fill_line;
      tag_q[idx] <= tag;
    end
  end

endmodule

//--- logic/l1d_mshr_if.sv
// outputs follow the probe and refill addresses combinationally and commands act on the next edge
`timescale 1ns/1ps

interface l1d_mshr_if #(
  parameter int MSHR_COUNT = 4
);

  logic [$clog2(MSHR_COUNT)-1:0] match_idx;
  logic [$clog2(MSHR_COUNT)-1:0] free_idx;
  logic [$clog2(MSHR_COUNT)-1:0] refill_idx;

  l1d_cfg_pkg::line_addr_t probe_addr;
  l1d_cfg_pkg::line_addr_t refill_addr;
  l1d_msg_pkg::lsu_req_t entry;
  l1d_msg_pkg::lsu_req_t head;
  logic alloc, append, pop, retire;
  logic match, match_full, free_any, head_valid;

  modport ctrl (output probe_addr, alloc, append, entry, refill_addr, pop, retire,
                input match, match_idx, match_full, free_any, free_idx, head, head_valid,
                refill_idx);
  modport mshr (input probe_addr, alloc, append, entry, refill_addr, pop, retire,
                output match, match_idx, match_full, free_any, free_idx, head, head_valid,
                refill_idx);

endinterface

//--- logic/l1d_array_if.sv
// the array has no handshake and every registered result appears one cycle after a lookup strobe
`timescale 1ns/1ps

interface l1d_array_if;

  logic lookup;
  l1d_cfg_pkg::line_addr_t line_addr;
  l1d_cfg_pkg::word_sel_t word_off;
  logic write;
  l1d_cfg_pkg::word_t wdata;
  logic fill;
  l1d_cfg_pkg::line_t fill_line;

  logic hit;
  l1d_cfg_pkg::word_t rdata;
  logic victim_dirty;
  l1d_cfg_pkg::line_addr_t victim_addr;
  l1d_cfg_pkg::line_t victim_line;

  modport ctrl (output lookup, line_addr, word_off, write, wdata, fill, fill_line,
                input hit, rdata, victim_dirty, victim_addr, victim_line);
  modport array (input lookup, line_addr, word_off, write, wdata, fill, fill_line,
                 output hit, rdata, victim_dirty, victim_addr, victim_line);

endinterface

//--- logic/l1d_msg_pkg.sv
// request tags mean nothing to the cache and only serve the LSU in pairing responses with requests
package l1d_msg_pkg;

  localparam int REQ_TAG_BITS = 6;

  typedef logic [REQ_TAG_BITS-1:0] req_tag_t;

  // one load or store from the LSU, also the payload of an MSHR queue slot
  typedef struct packed {
    l1d_cfg_pkg::paddr_t addr;
    l1d_cfg_pkg::word_t wdata;
    logic we;
    req_tag_t tag;
  } lsu_req_t;

  // a store is acknowledged with we set and rdata holding the old word
  typedef struct packed {
    req_tag_t tag;
    l1d_cfg_pkg::word_t rdata;
    logic we;
  } lsu_resp_t;

endpackage

//--- logic/l1d_cfg_pkg.sv
// word and line sizes must stay powers of two because the offsets are cut straight from a byte address
package l1d_cfg_pkg;

  localparam int WORD_BITS = 64;
  localparam int PADDR_BITS = 22;
  localparam int LINE_WORDS = 4;

  // a byte address splits into line address, word select and byte offset
  localparam int BYTE_OFF_BITS = $clog2(WORD_BITS / 8);
  localparam int WORD_SEL_BITS = $clog2(LINE_WORDS);
  localparam int OFFSET_BITS = BYTE_OFF_BITS + WORD_SEL_BITS;
  localparam int LINE_ADDR_BITS = PADDR_BITS - OFFSET_BITS;

  typedef logic [WORD_BITS-1:0] word_t;
  typedef logic [LINE_WORDS-1:0][WORD_BITS-1:0] line_t;
  typedef logic [PADDR_BITS-1:0] paddr_t;
  typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;
  typedef logic [WORD_SEL_BITS-1:0] word_sel_t;

  function automatic line_addr_t line_of(paddr_t addr);
    return addr[PADDR_BITS-1:OFFSET_BITS];
  endfunction

  function automatic word_sel_t word_of(paddr_t addr);
    return addr[OFFSET_BITS-1:BYTE_OFF_BITS];
  endfunction

endpackage
